/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_conv
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: sim clean

# a run that aborts early leaves no pass line and counts as failed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
rtl/conv_geom_pkg.sv
rtl/conv_num_pkg.sv
rtl/mac_pe.sv
rtl/lane_skew.sv
rtl/ifmap_gather.sv
rtl/systolic_array.sv
rtl/ofmap_serializer.sv
rtl/conv_top.sv
tb/tb_clk_gen.sv
tb/conv_chk.sv
tb/tb_conv.sv

/* rtl/conv_geom_pkg.sv */
`default_nettype none

package conv_geom_pkg;

  // rows take input channels, columns give output channels
  localparam int ARRAY_HEIGHT = 4;
  localparam int ARRAY_WIDTH  = 4;

  // one full weight load, row-major over (ic, oc)
  localparam int WEIGHT_COUNT = ARRAY_HEIGHT * ARRAY_WIDTH;

endpackage

`default_nettype wire

/* rtl/conv_num_pkg.sv */
`default_nettype none

package conv_num_pkg;

  localparam int IFMAP_WIDTH  = 16;  // signed activation
  localparam int WEIGHT_WIDTH = 16;  // signed weight
  localparam int OFMAP_WIDTH  = 32;  // signed psum, wraps

endpackage

`default_nettype wire

/* rtl/conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_top (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire  [conv_num_pkg::WEIGHT_WIDTH-1:0] weights_dat,
  input  wire                                  weights_vld,
  input  wire  [conv_num_pkg::IFMAP_WIDTH-1:0]  ifmap_dat,
  input  wire                                  ifmap_vld,
  output logic [conv_num_pkg::OFMAP_WIDTH-1:0]  ofmap_dat,
  output logic                                 ofmap_vld
);

  logic [conv_geom_pkg::ARRAY_HEIGHT*conv_num_pkg::IFMAP_WIDTH-1:0] vec;
  logic [conv_geom_pkg::ARRAY_HEIGHT*conv_num_pkg::IFMAP_WIDTH-1:0] a_lanes;
  logic [conv_geom_pkg::ARRAY_WIDTH*conv_num_pkg::OFMAP_WIDTH-1:0]  col_sum;
  logic [conv_geom_pkg::ARRAY_WIDTH*conv_num_pkg::OFMAP_WIDTH-1:0]  sums;
  logic vec_vld;
  logic a_vld;    // aligned with lane 0
  logic col_vld;  // aligned with column 0
  logic sum_vld;

  ifmap_gather u_gather (
    .clk       (clk),
    .rst_n     (rst_n),
    .ifmap_dat (ifmap_dat),
    .ifmap_vld (ifmap_vld),
    .vec       (vec),
    .vec_vld   (vec_vld)
  );

  lane_skew #(
    .LANES      (conv_geom_pkg::ARRAY_HEIGHT),
    .LANE_WIDTH (conv_num_pkg::IFMAP_WIDTH),
    .REVERSE    (1'b0)
  ) u_in_skew (
    .clk      (clk),
    .rst_n    (rst_n),
    .din      (vec),
    .din_vld  (vec_vld),
    .dout     (a_lanes),
    .dout_vld (a_vld)
  );

  systolic_array u_array (
    .clk         (clk),
    .rst_n       (rst_n),
    .weights_dat (weights_dat),
    .weights_vld (weights_vld),
    .a_lanes     (a_lanes),
    .vec_vld     (a_vld),
    .col_sum     (col_sum),
    .col_vld     (col_vld)
  );

  // undo the column skew
  lane_skew #(
    .LANES      (conv_geom_pkg::ARRAY_WIDTH),
    .LANE_WIDTH (conv_num_pkg::OFMAP_WIDTH),
    .REVERSE    (1'b1)
  ) u_out_skew (
    .clk      (clk),
    .rst_n    (rst_n),
    .din      (col_sum),
    .din_vld  (col_vld),
    .dout     (sums),
    .dout_vld (sum_vld)
  );

  ofmap_serializer u_ser (
    .clk       (clk),
    .rst_n     (rst_n),
    .sums      (sums),
    .sum_vld   (sum_vld),
    .ofmap_dat (ofmap_dat),
    .ofmap_vld (ofmap_vld)
  );

endmodule

`default_nettype wire

/* rtl/ifmap_gather.sv */
`timescale 1ns/1ps
`default_nettype none

module ifmap_gather (
  input  wire                                                      clk,
  input  wire                                                      rst_n,
  input  wire  [conv_num_pkg::IFMAP_WIDTH-1:0]                      ifmap_dat,
  input  wire                                                      ifmap_vld,
  output logic [conv_geom_pkg::ARRAY_HEIGHT*conv_num_pkg::IFMAP_WIDTH-1:0] vec,
  output logic                                                     vec_vld
);

  import conv_geom_pkg::*;
  import conv_num_pkg::*;

  localparam int CNT_W = $clog2(ARRAY_HEIGHT);

  logic [CNT_W-1:0] lane_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_cnt <= '0;
      vec_vld  <= 1'b0;
    end else begin
      vec_vld <= 1'b0;
      if (ifmap_vld) begin
        if (lane_cnt == CNT_W'(ARRAY_HEIGHT - 1)) begin
          lane_cnt <= '0;
          vec_vld  <= 1'b1;  // vector complete
        end else begin
          lane_cnt <= lane_cnt + 1'b1;
        end
      end
    end
  end

  // lane k of vec holds input channel k
  always_ff @(posedge clk) begin
    if (ifmap_vld)
      vec[lane_cnt*IFMAP_WIDTH +: IFMAP_WIDTH] <= ifmap_dat;
  end

endmodule

`default_nettype wire

/* rtl/lane_skew.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_skew #(
  parameter int LANES      = conv_geom_pkg::ARRAY_HEIGHT,
  parameter int LANE_WIDTH = conv_num_pkg::IFMAP_WIDTH,
  parameter bit REVERSE    = 1'b0  // deepest on lane 0
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire  [LANES*LANE_WIDTH-1:0]  din,
  input  wire                          din_vld,
  output logic [LANES*LANE_WIDTH-1:0]  dout,
  output logic                         dout_vld
);

  localparam int VLD_DEPTH = REVERSE ? LANES - 1 : 0;

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    localparam int DEPTH = REVERSE ? LANES - 1 - k : k;

    if (DEPTH == 0) begin : g_pass
      assign dout[k*LANE_WIDTH +: LANE_WIDTH] = din[k*LANE_WIDTH +: LANE_WIDTH];
    end else begin : g_dly
      logic [LANE_WIDTH-1:0] chain [DEPTH];

      always_ff @(posedge clk) begin
        chain[0] <= din[k*LANE_WIDTH +: LANE_WIDTH];
        for (int i = 1; i < DEPTH; i++)
          chain[i] <= chain[i-1];
      end

      assign dout[k*LANE_WIDTH +: LANE_WIDTH] = chain[DEPTH-1];
    end
  end

  // valid follows lane 0
  if (VLD_DEPTH == 0) begin : g_vld_pass
    assign dout_vld = din_vld;
  end else begin : g_vld_dly
    logic [VLD_DEPTH-1:0] vld_sr;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
        vld_sr <= '0;
      else
        vld_sr <= {vld_sr[VLD_DEPTH-2:0], din_vld};
    end

    assign dout_vld = vld_sr[VLD_DEPTH-1];
  end

endmodule

`default_nettype wire

/* rtl/mac_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_pe (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire                                   w_load,
  input  wire  [conv_num_pkg::WEIGHT_WIDTH-1:0] w_in,
  input  wire  [conv_num_pkg::IFMAP_WIDTH-1:0]  a_in,
  output logic [conv_num_pkg::IFMAP_WIDTH-1:0]  a_out,
  input  wire  [conv_num_pkg::OFMAP_WIDTH-1:0]  psum_in,
  output logic [conv_num_pkg::OFMAP_WIDTH-1:0]  psum_out
);

  import conv_num_pkg::*;

  logic signed [WEIGHT_WIDTH-1:0]             w_q;
  logic signed [IFMAP_WIDTH+WEIGHT_WIDTH-1:0] prod;

  // stationary weight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      w_q <= '0;
    else if (w_load)
      w_q <= w_in;
  end

  assign prod = $signed(a_in) * w_q;

  always_ff @(posedge clk) begin
    a_out    <= a_in;                           // on to the right
    psum_out <= psum_in + OFMAP_WIDTH'(prod);   // mod 2^32
  end

endmodule

`default_nettype wire

/* rtl/ofmap_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module ofmap_serializer (
  input  wire                                                     clk,
  input  wire                                                     rst_n,
  input  wire  [conv_geom_pkg::ARRAY_WIDTH*conv_num_pkg::OFMAP_WIDTH-1:0] sums,
  input  wire                                                     sum_vld,
  output logic [conv_num_pkg::OFMAP_WIDTH-1:0]                     ofmap_dat,
  output logic                                                    ofmap_vld
);

  import conv_geom_pkg::*;
  import conv_num_pkg::*;

  localparam int CH_W = $clog2(ARRAY_WIDTH);

  logic [ARRAY_WIDTH*OFMAP_WIDTH-1:0] hold;
  logic [CH_W-1:0]                    ch;

  // new vector may land on the last channel of the previous one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ch        <= '0;
      ofmap_vld <= 1'b0;
    end else if (sum_vld) begin
      ch        <= '0;
      ofmap_vld <= 1'b1;
    end else if (ofmap_vld) begin
      ch <= ch + 1'b1;
      if (ch == CH_W'(ARRAY_WIDTH - 1))
        ofmap_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (sum_vld)
      hold <= sums;
  end

  assign ofmap_dat = hold[ch*OFMAP_WIDTH +: OFMAP_WIDTH];  // channel order 0..3

endmodule

`default_nettype wire

/* rtl/systolic_array.sv */
`timescale 1ns/1ps
`default_nettype none

module systolic_array (
  input  wire                                                      clk,
  input  wire                                                      rst_n,
  input  wire  [conv_num_pkg::WEIGHT_WIDTH-1:0]                     weights_dat,
  input  wire                                                      weights_vld,
  input  wire  [conv_geom_pkg::ARRAY_HEIGHT*conv_num_pkg::IFMAP_WIDTH-1:0] a_lanes,
  input  wire                                                      vec_vld,
  output logic [conv_geom_pkg::ARRAY_WIDTH*conv_num_pkg::OFMAP_WIDTH-1:0]  col_sum,
  output logic                                                     col_vld
);

  import conv_geom_pkg::*;
  import conv_num_pkg::*;

  localparam int WCNT_W = $clog2(WEIGHT_COUNT);

  logic [WCNT_W-1:0]       w_cnt;
  logic [ARRAY_HEIGHT-1:0] vld_sr;

  // a_h[r][c] feeds pe (r,c) from the left, ps_v[r][c] from above
  logic [IFMAP_WIDTH-1:0] a_h  [ARRAY_HEIGHT][ARRAY_WIDTH+1];
  logic [OFMAP_WIDTH-1:0] ps_v [ARRAY_HEIGHT+1][ARRAY_WIDTH];

  // word n goes to row n/ARRAY_WIDTH, column n%ARRAY_WIDTH
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_cnt <= '0;
    end else if (weights_vld) begin
      if (w_cnt == WCNT_W'(WEIGHT_COUNT - 1))
        w_cnt <= '0;
      else
        w_cnt <= w_cnt + 1'b1;
    end
  end

  for (genvar r = 0; r < ARRAY_HEIGHT; r++) begin : g_row
    assign a_h[r][0] = a_lanes[r*IFMAP_WIDTH +: IFMAP_WIDTH];

    for (genvar c = 0; c < ARRAY_WIDTH; c++) begin : g_col
      mac_pe u_pe (
        .clk      (clk),
        .rst_n    (rst_n),
        .w_load   (weights_vld && (w_cnt == WCNT_W'(r*ARRAY_WIDTH + c))),
        .w_in     (weights_dat),
        .a_in     (a_h[r][c]),
        .a_out    (a_h[r][c+1]),
        .psum_in  (ps_v[r][c]),
        .psum_out (ps_v[r+1][c])
      );
    end
  end

  for (genvar c = 0; c < ARRAY_WIDTH; c++) begin : g_edge
    assign ps_v[0][c] = '0;  // sums start at zero
    assign col_sum[c*OFMAP_WIDTH +: OFMAP_WIDTH] = ps_v[ARRAY_HEIGHT][c];
  end

  // one stage per row
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      vld_sr <= '0;
    else
      vld_sr <= {vld_sr[ARRAY_HEIGHT-2:0], vec_vld};
  end

  assign col_vld = vld_sr[ARRAY_HEIGHT-1];

endmodule

`default_nettype wire

/* tb/conv_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_chk (
  input wire                                  clk,
  input wire                                  rst_n,
  input wire                                  ifmap_vld,
  input wire [conv_num_pkg::OFMAP_WIDTH-1:0] ofmap_dat,
  input wire                                  ofmap_vld
);

  import conv_geom_pkg::*;

  localparam int LATENCY = 9;  // 4th ifmap word to 1st ofmap word
  localparam int WCNT_W  = $clog2(ARRAY_HEIGHT);
  localparam int RCNT_W  = $clog2(ARRAY_WIDTH);

  logic [WCNT_W-1:0]  word_cnt;
  logic [RCNT_W-1:0]  run_cnt;  // position inside the current group of outputs
  logic [LATENCY-1:0] done_sr;
  logic               vec_done;

  assign vec_done = ifmap_vld && (word_cnt == WCNT_W'(ARRAY_HEIGHT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
      run_cnt  <= '0;
      done_sr  <= '0;
    end else begin
      if (ifmap_vld)
        word_cnt <= vec_done ? '0 : word_cnt + 1'b1;
      run_cnt <= ofmap_vld ? run_cnt + 1'b1 : '0;  // wraps every ARRAY_WIDTH words
      done_sr <= {done_sr[LATENCY-2:0], vec_done};
    end
  end

  // async clear, so look between edges
  a_rst_quiet: assert property (@(negedge clk) !rst_n |-> !ofmap_vld)
    else $error("ofmap_vld high while in reset");

  a_whole_groups: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(ofmap_vld) |-> run_cnt == '0)
    else $error("ofmap_vld dropped in the middle of a group of four");

  a_not_early: assert property (@(posedge clk) disable iff (!rst_n)
    (ofmap_vld && run_cnt == '0) |-> done_sr[LATENCY-1])
    else $error("output group started before 9 cycles after a complete vector");

  a_group_per_vec: assert property (@(posedge clk) disable iff (!rst_n)
    done_sr[LATENCY-1] |-> (ofmap_vld && run_cnt == '0))
    else $error("complete vector gave no output group on the 9th edge");

  a_no_x: assert property (@(posedge clk) disable iff (!rst_n)
    ofmap_vld |-> !$isunknown(ofmap_dat))
    else $error("ofmap_dat unknown while ofmap_vld high");

endmodule

bind conv_top conv_chk u_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .ifmap_vld (ifmap_vld),
  .ofmap_dat (ofmap_dat),
  .ofmap_vld (ofmap_vld)
);

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 20,  // ns, 40 ns clock
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // release on a rising edge, like the rest of the stimulus
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_conv.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_conv;

  import conv_geom_pkg::*;
  import conv_num_pkg::*;

  localparam int N_IDENT   = 8;
  localparam int N_RAND    = 24;
  localparam int N_B2B     = 40;
  localparam int N_RELOAD  = 12;  // per weight set
  localparam int N_EXTREME = 4;
  localparam int WORDS = (N_IDENT + N_RAND + N_B2B + 2 * N_RELOAD + N_EXTREME) * ARRAY_HEIGHT
                         + 6 * WEIGHT_COUNT;
  localparam int CYCLE_LIMIT = WORDS * 8 + 400;
  localparam int DRAIN_LIMIT = 20;  // last word needs 9 + 3 edges
  localparam logic [15:0] LFSR_SEED = 16'd3024;

  logic                    clk;
  logic                    rst_n;
  logic [WEIGHT_WIDTH-1:0] weights_dat;
  logic                    weights_vld;
  logic [IFMAP_WIDTH-1:0]  ifmap_dat;
  logic                    ifmap_vld;
  logic [OFMAP_WIDTH-1:0]  ofmap_dat;
  logic                    ofmap_vld;

  logic signed [WEIGHT_WIDTH-1:0] wtab [ARRAY_HEIGHT][ARRAY_WIDTH];  // what the PEs hold
  logic signed [IFMAP_WIDTH-1:0]  vec  [ARRAY_HEIGHT];
  logic [OFMAP_WIDTH-1:0]         exp_q [$];
  logic [15:0]                    lfsr;
  string                          test_name;
  int test_errs = 0;
  int pass_cnt  = 0;
  int fail_cnt  = 0;
  int cycles    = 0;

  tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

  conv_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .weights_dat (weights_dat),
    .weights_vld (weights_vld),
    .ifmap_dat   (ifmap_dat),
    .ifmap_vld   (ifmap_vld),
    .ofmap_dat   (ofmap_dat),
    .ofmap_vld   (ofmap_vld)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // out[oc] = sum over ic of a[ic] * w[ic][oc], mod 2^32
  function automatic logic signed [OFMAP_WIDTH-1:0] conv_ref(
    input logic signed [WEIGHT_WIDTH-1:0] w [ARRAY_HEIGHT][ARRAY_WIDTH],
    input logic signed [IFMAP_WIDTH-1:0]  a [ARRAY_HEIGHT],
    input int                             oc
  );
    longint acc;
    acc = 0;
    for (int ic = 0; ic < ARRAY_HEIGHT; ic++)
      acc += longint'(a[ic]) * longint'(w[ic][oc]);
    return acc[OFMAP_WIDTH-1:0];
  endfunction

  task automatic check_ofmap(input logic signed [OFMAP_WIDTH-1:0] exp,
                             input logic signed [OFMAP_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("ERR %s: expected %0d, actual %0d", test_name, exp, act);
      test_errs++;
    end
  endtask

  task automatic send_weights();
    for (int n = 0; n < WEIGHT_COUNT; n++) begin
      @(posedge clk);
      weights_dat <= wtab[n / ARRAY_WIDTH][n % ARRAY_WIDTH];
      weights_vld <= 1'b1;
    end
    @(posedge clk);
    weights_vld <= 1'b0;
  endtask

  task automatic send_vector(input int gap);
    for (int ic = 0; ic < ARRAY_HEIGHT; ic++) begin
      @(posedge clk);
      ifmap_dat <= vec[ic];
      ifmap_vld <= 1'b1;
    end
    for (int oc = 0; oc < ARRAY_WIDTH; oc++)
      exp_q.push_back(conv_ref(wtab, vec, oc));
    repeat (gap) begin
      @(posedge clk);
      ifmap_vld <= 1'b0;
    end
  endtask

  task automatic random_vector();
    logic [31:0] r;
    foreach (vec[ic]) begin
      rand_bits(IFMAP_WIDTH, r);
      vec[ic] = r[IFMAP_WIDTH-1:0];
    end
  endtask

  // gap < 0 picks a random gap of 0 to 3 cycles per vector
  task automatic random_block(input int n, input int gap);
    logic [31:0] r;
    foreach (wtab[ic, oc]) begin
      rand_bits(WEIGHT_WIDTH, r);
      wtab[ic][oc] = r[WEIGHT_WIDTH-1:0];
    end
    send_weights();
    repeat (n) begin
      random_vector();
      if (gap < 0) begin
        rand_bits(2, r);
        send_vector(int'(r[1:0]));
      end else begin
        send_vector(gap);
      end
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    @(posedge clk);
    ifmap_vld <= 1'b0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d expected output words never came out", test_name, exp_q.size());
      test_errs++;
      exp_q.delete();
    end
    repeat (ARRAY_WIDTH) @(posedge clk);  // room for stray words to show up
  endtask

  task automatic finish_test();
    drain_outputs();
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %s: pass", test_name);
    end else begin
      fail_cnt++;
      $display("test %s: fail with %0d errors", test_name, test_errs);
    end
    test_errs = 0;
  endtask

  // outputs are registered, so compare away from the rising edge
  always @(negedge clk) begin
    if (rst_n && ofmap_vld) begin
      if (exp_q.size() == 0) begin
        $display("%s: output word %0d came out with none expected", test_name, ofmap_dat);
        test_errs++;
      end else begin
        check_ofmap(exp_q.pop_front(), ofmap_dat);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    weights_dat = '0;
    weights_vld = 1'b0;
    ifmap_dat   = '0;
    ifmap_vld   = 1'b0;
    lfsr        = LFSR_SEED;
    @(posedge rst_n);
    @(posedge clk);

    test_name = "identity";
    foreach (wtab[ic, oc])
      wtab[ic][oc] = (ic == oc) ? 16'sd1 : 16'sd0;
    send_weights();
    repeat (N_IDENT) begin
      random_vector();
      send_vector(2);
    end
    finish_test();

    test_name = "random";
    random_block(N_RAND, 1);
    finish_test();

    test_name = "back_to_back";
    random_block(N_B2B, -1);
    finish_test();

    test_name = "reload";
    random_block(N_RELOAD, 0);
    drain_outputs();
    random_block(N_RELOAD, 0);  // counter wrapped, second table
    finish_test();

    test_name = "extreme";
    foreach (wtab[ic, oc])
      wtab[ic][oc] = 16'sh8000;  // -32768
    send_weights();
    repeat (N_EXTREME) begin
      foreach (vec[ic])
        vec[ic] = 16'sh8000;
      send_vector(0);
    end
    finish_test();

    $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
